// ==== logic/execStage.sv ====
`timescale 1ns/10ps

module execStage (
    input  logic                clk,
    input  logic                rstN,
    input  mipsPkg::pipeCtrl_t  ctrl,
    input  mipsPkg::idEx_t      idEx,
    input  mipsPkg::wbTrace_t   wb,
    output mipsPkg::redirect_t  redirect,
    output mipsPkg::exMem_t     exMem
);
    import mipsPkg::*;

    logic  memIsLoad;
    word_t opA, rtFwd, opB, result;

    // memory stage first, then writeback, else the decode-time value
    function automatic word_t fwd(regAddr_t r, word_t regVal, exMem_t m, logic mLoad,
                                  wbTrace_t w);
        word_t value;
        if (m.wen && !mLoad && m.dest == r) value = m.aluResult;
        else if (w.wen && w.wnum == r) value = w.wdata;
        else value = regVal;
        return value;
    endfunction

    always_comb begin
        memIsLoad = exMem.memOp inside {memLw, memLb, memLbu};
        opA = fwd(idEx.rs, idEx.rsVal, exMem, memIsLoad, wb);
        rtFwd = fwd(idEx.rt, idEx.rtVal, exMem, memIsLoad, wb);
        opB = idEx.aluSrcImm ? idEx.imm : rtFwd;
        case (idEx.aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluXor:  result = opA ^ opB;
            aluNor:  result = ~(opA | opB);
            aluSlt:  result = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu: result = {{(dataWidth-1){1'b0}}, opA < opB};
            aluSll:  result = opB << idEx.sa;
            aluSrl:  result = opB >> idEx.sa;
            aluSra:  result = $signed(opB) >>> idEx.sa;
            aluLui:  result = {opB[15:0], 16'h0000};
            default: result = opB;
        endcase
        if (idEx.branchOp == brJump) begin
            result = idEx.pc + 32'd8;  // jal link, past the delay slot
        end
    end

    always_comb begin
        redirect.target = idEx.branchTarget;
        case (idEx.branchOp)
            brBeq:   redirect.taken = (opA == rtFwd);
            brBne:   redirect.taken = (opA != rtFwd);
            brJump:  redirect.taken = 1'b1;
            default: redirect.taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem.wen <= 1'b0;
            exMem.memOp <= memNone;
        end else if (!ctrl.stallM) begin
            exMem.pc <= idEx.pc;
            exMem.aluResult <= result;
            exMem.storeData <= rtFwd;
            exMem.dest <= idEx.dest;
            exMem.wen <= idEx.wen;
            exMem.memOp <= idEx.memOp;
        end
    end

endmodule

// ==== logic/instDecode.sv ====
`timescale 1ns/10ps

module instDecode (
    input  logic                clk,
    input  logic                rstN,
    input  mipsPkg::pipeCtrl_t  ctrl,
    input  mipsPkg::fetchOut_t  fetchOut,
    output mipsPkg::regAddr_t   rsAddr,
    output mipsPkg::regAddr_t   rtAddr,
    input  mipsPkg::word_t      rsData,
    input  mipsPkg::word_t      rtData,
    output mipsPkg::idEx_t      idEx
);
    import mipsPkg::*;

    opcode_t op;
    funct_t  fn;
    word_t   signImm, zeroImm;
    idEx_t   dec;

    assign op = opcode_t'(fetchOut.instr[31:26]);
    assign fn = funct_t'(fetchOut.instr[5:0]);
    assign rsAddr = fetchOut.instr[25:21];
    assign rtAddr = fetchOut.instr[20:16];
    assign signImm = {{(dataWidth-16){fetchOut.instr[15]}}, fetchOut.instr[15:0]};
    assign zeroImm = {{(dataWidth-16){1'b0}}, fetchOut.instr[15:0]};

    always_comb begin
        dec = '0;
        dec.pc = fetchOut.pc;
        dec.rs = rsAddr;
        dec.rt = rtAddr;
        dec.rsVal = rsData;
        dec.rtVal = rtData;
        dec.sa = fetchOut.instr[10:6];
        dec.imm = signImm;
        dec.dest = rtAddr;
        dec.wen = 1'b0;
        dec.aluOp = aluPassB;
        dec.aluSrcImm = 1'b1;
        dec.memOp = memNone;
        dec.branchOp = brNone;
        dec.branchTarget = fetchOut.pcPlus4 + {signImm[dataWidth-3:0], 2'b00};
        case (op)
            opSpecial: begin
                dec.dest = fetchOut.instr[15:11];  // rd
                dec.aluSrcImm = 1'b0;
                dec.wen = 1'b1;
                case (fn)
                    fnAddu:  dec.aluOp = aluAdd;
                    fnSubu:  dec.aluOp = aluSub;
                    fnAnd:   dec.aluOp = aluAnd;
                    fnOr:    dec.aluOp = aluOr;
                    fnXor:   dec.aluOp = aluXor;
                    fnNor:   dec.aluOp = aluNor;
                    fnSlt:   dec.aluOp = aluSlt;
                    fnSltu:  dec.aluOp = aluSltu;
                    fnSll:   dec.aluOp = aluSll;
                    fnSrl:   dec.aluOp = aluSrl;
                    fnSra:   dec.aluOp = aluSra;
                    default: dec.wen = 1'b0;
                endcase
            end
            opJ, opJal: begin
                dec.branchOp = brJump;
                dec.branchTarget = {fetchOut.pcPlus4[31:28], fetchOut.instr[25:0], 2'b00};
                if (op == opJal) begin
                    dec.dest = linkReg;
                    dec.wen = 1'b1;
                end
            end
            opBeq: dec.branchOp = brBeq;
            opBne: dec.branchOp = brBne;
            opAddiu: begin
                dec.aluOp = aluAdd;
                dec.wen = 1'b1;
            end
            opSlti: begin
                dec.aluOp = aluSlt;
                dec.wen = 1'b1;
            end
            opAndi, opOri, opXori: begin
                dec.imm = zeroImm;
                dec.wen = 1'b1;
                dec.aluOp = (op == opAndi) ? aluAnd : (op == opOri) ? aluOr : aluXor;
            end
            opLui: begin
                dec.aluOp = aluLui;
                dec.wen = 1'b1;
            end
            opLw, opLb, opLbu: begin
                dec.aluOp = aluAdd;
                dec.wen = 1'b1;
                dec.memOp = (op == opLw) ? memLw : (op == opLb) ? memLb : memLbu;
            end
            opSw, opSb: begin
                dec.aluOp = aluAdd;
                dec.memOp = (op == opSw) ? memSw : memSb;
            end
            default: ;  // anything else retires as a nop
        endcase
        if (dec.dest == '0) begin
            dec.wen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx.wen <= 1'b0;
            idEx.memOp <= memNone;
            idEx.branchOp <= brNone;
        end else if (!ctrl.stallE) begin
            if (ctrl.bubbleE) begin
                idEx.wen <= 1'b0;
                idEx.memOp <= memNone;
                idEx.branchOp <= brNone;
            end else begin
                idEx <= dec;
            end
        end
    end

endmodule

// ==== logic/instFetch.sv ====
`timescale 1ns/10ps

module instFetch (
    input  logic                clk,
    input  logic                rstN,
    input  mipsPkg::pipeCtrl_t  ctrl,
    input  mipsPkg::redirect_t  redirect,
    input  mipsPkg::word_t      instr,
    output mipsPkg::word_t      pc,
    output logic                instEn,
    output mipsPkg::fetchOut_t  fetchOut
);
    import mipsPkg::*;

    logic  started;  // low in the first cycle after reset
    word_t pcPlus4;

    assign pcPlus4 = pc + 32'd4;
    assign instEn = started & ~redirect.taken;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            started <= 1'b0;
            pc <= resetPc;
        end else begin
            started <= 1'b1;
            if (started && !ctrl.stallF) begin
                pc <= redirect.taken ? redirect.target : pcPlus4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchOut <= '0;
        end else if (!ctrl.stallD) begin
            fetchOut.pc <= pc;
            fetchOut.pcPlus4 <= pcPlus4;
            fetchOut.instr <= (ctrl.bubbleD || !started) ? '0 : instr;  // zero is sll $0 nop
        end
    end

endmodule

// ==== logic/memAccess.sv ====
`timescale 1ns/10ps

module memAccess (
    input  logic                clk,
    input  logic                rstN,
    input  mipsPkg::pipeCtrl_t  ctrl,
    input  mipsPkg::exMem_t     exMem,
    input  mipsPkg::word_t      memRdata,
    output mipsPkg::dataReq_t   dataReq,
    output mipsPkg::wbTrace_t   wb
);
    import mipsPkg::*;

    logic [1:0] byteSel;
    logic [7:0] loadByte;
    word_t      loadData;
    logic       isLoad;

    assign byteSel = exMem.aluResult[1:0];
    assign loadByte = memRdata[8*byteSel +: 8];
    assign isLoad = exMem.memOp inside {memLw, memLb, memLbu};

    always_comb begin
        dataReq.en = (exMem.memOp != memNone);
        dataReq.addr = {exMem.aluResult[dataWidth-1:2], 2'b00};  // word address
        dataReq.wen = 4'b0000;
        dataReq.wdata = exMem.storeData;
        case (exMem.memOp)
            memSw: dataReq.wen = 4'b1111;
            memSb: begin
                dataReq.wen = 4'b0001 << byteSel;
                dataReq.wdata = {4{exMem.storeData[7:0]}};  // byte on every lane
            end
            default: ;
        endcase
    end

    always_comb begin
        case (exMem.memOp)
            memLb:   loadData = {{(dataWidth-8){loadByte[7]}}, loadByte};
            memLbu:  loadData = {{(dataWidth-8){1'b0}}, loadByte};
            default: loadData = memRdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb.wen <= 1'b0;
        end else if (!ctrl.stallM) begin
            wb.pc <= exMem.pc;
            wb.wen <= exMem.wen;
            wb.wnum <= exMem.dest;
            wb.wdata <= isLoad ? loadData : exMem.aluResult;
        end
    end

endmodule

// ==== logic/mipsCore.sv ====
`timescale 1ns/10ps

module mipsCore (
    input  logic               clk,
    input  logic               rstN,
    output mipsPkg::word_t     pc,
    output logic               instEn,
    input  mipsPkg::word_t     instr,
    input  logic               iCacheStall,
    output mipsPkg::dataReq_t  dataReq,
    input  mipsPkg::word_t     memRdata,
    input  logic               dCacheStall,
    output mipsPkg::wbTrace_t  wbTrace
);
    import mipsPkg::*;

    pipeCtrl_t ctrl;
    redirect_t redirect;
    fetchOut_t fetchOut;
    idEx_t     idEx;
    exMem_t    exMem;
    regAddr_t  rsAddr, rtAddr;
    word_t     rsData, rtData;

    instFetch instFetch0 (
        .clk(clk), .rstN(rstN),
        .ctrl(ctrl),
        .redirect(redirect),
        .instr(instr),
        .pc(pc),
        .instEn(instEn),
        .fetchOut(fetchOut)
    );

    instDecode instDecode0 (
        .clk(clk), .rstN(rstN),
        .ctrl(ctrl),
        .fetchOut(fetchOut),
        .rsAddr(rsAddr), .rtAddr(rtAddr),
        .rsData(rsData), .rtData(rtData),
        .idEx(idEx)
    );

    regFile regFile0 (
        .clk(clk),
        .rsAddr(rsAddr), .rtAddr(rtAddr),
        .rsData(rsData), .rtData(rtData),
        .wb(wbTrace)  // writeback bus doubles as the trace
    );

    execStage execStage0 (
        .clk(clk), .rstN(rstN),
        .ctrl(ctrl),
        .idEx(idEx),
        .wb(wbTrace),
        .redirect(redirect),
        .exMem(exMem)
    );

    pipeHazard pipeHazard0 (
        .iCacheStall(iCacheStall),
        .dCacheStall(dCacheStall),
        .fetchOut(fetchOut),
        .idEx(idEx),
        .redirect(redirect),
        .ctrl(ctrl)
    );

    memAccess memAccess0 (
        .clk(clk), .rstN(rstN),
        .ctrl(ctrl),
        .exMem(exMem),
        .memRdata(memRdata),
        .dataReq(dataReq),
        .wb(wbTrace)
    );

endmodule

// ==== logic/mipsPkg.sv ====
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam logic [dataWidth-1:0] resetPc = 32'hBFC00000;
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opSlti    = 6'h0A,
        opAndi    = 6'h0C,
        opOri     = 6'h0D,
        opXori    = 6'h0E,
        opLui     = 6'h0F,
        opLb      = 6'h20,
        opLw      = 6'h23,
        opLbu     = 6'h24,
        opSb      = 6'h28,
        opSw      = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnSra  = 6'h03,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2A,
        fnSltu = 6'h2B
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt,
        aluSltu, aluSll, aluSrl, aluSra, aluLui, aluPassB
    } aluOp_t;

    typedef enum logic [2:0] {
        memNone, memLw, memLb, memLbu, memSw, memSb
    } memOp_t;

    typedef enum logic [1:0] {
        brNone, brBeq, brBne, brJump
    } branchOp_t;

    typedef struct packed {
        word_t pc;
        word_t pcPlus4;
        word_t instr;
    } fetchOut_t;

    typedef struct packed {
        word_t     pc;
        regAddr_t  rs;
        word_t     rsVal;
        regAddr_t  rt;
        word_t     rtVal;
        regAddr_t  dest;
        logic      wen;
        word_t     imm;
        logic [4:0] sa;
        aluOp_t    aluOp;
        logic      aluSrcImm;
        memOp_t    memOp;
        branchOp_t branchOp;
        word_t     branchTarget;
    } idEx_t;

    typedef struct packed {
        word_t    pc;
        word_t    aluResult;
        word_t    storeData;
        regAddr_t dest;
        logic     wen;
        memOp_t   memOp;
    } exMem_t;

    typedef struct packed {
        word_t    pc;
        logic     wen;
        regAddr_t wnum;
        word_t    wdata;
    } wbTrace_t;

    typedef struct packed {
        logic       en;
        logic [3:0] wen;
        word_t      addr;
        word_t      wdata;
    } dataReq_t;

    typedef struct packed {
        logic stallF;
        logic stallD;
        logic stallE;
        logic stallM;
        logic bubbleD;
        logic bubbleE;
    } pipeCtrl_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// ==== logic/pipeHazard.sv ====
`timescale 1ns/10ps

module pipeHazard (
    input  logic                iCacheStall,
    input  logic                dCacheStall,
    input  mipsPkg::fetchOut_t  fetchOut,
    input  mipsPkg::idEx_t      idEx,
    input  mipsPkg::redirect_t  redirect,
    output mipsPkg::pipeCtrl_t  ctrl
);
    import mipsPkg::*;

    regAddr_t rsD, rtD;
    opcode_t  opD;
    logic     loadUse, branchInD, holdD, taken;

    assign rsD = fetchOut.instr[25:21];
    assign rtD = fetchOut.instr[20:16];
    assign opD = opcode_t'(fetchOut.instr[31:26]);
    assign taken = redirect.taken;

    assign loadUse = (idEx.memOp inside {memLw, memLb, memLbu}) && idEx.wen &&
                     (idEx.dest != '0) && (idEx.dest == rsD || idEx.dest == rtD);

    // a branch must not leave decode before its delay slot is fetched
    assign branchInD = opD inside {opBeq, opBne, opJ, opJal};
    assign holdD = loadUse | (iCacheStall & branchInD);

    always_comb begin
        ctrl.stallF = dCacheStall | (~taken & (holdD | iCacheStall));
        ctrl.stallD = dCacheStall | (~taken & holdD);
        ctrl.bubbleD = ~dCacheStall & (taken | (~holdD & iCacheStall));
        ctrl.stallE = dCacheStall;
        ctrl.bubbleE = ~dCacheStall & ~taken & holdD;
        ctrl.stallM = dCacheStall;  // also freezes writeback
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic               clk,
    input  mipsPkg::regAddr_t  rsAddr,
    input  mipsPkg::regAddr_t  rtAddr,
    output mipsPkg::word_t     rsData,
    output mipsPkg::word_t     rtData,
    input  mipsPkg::wbTrace_t  wb
);
    import mipsPkg::*;

    word_t regs [2**regAddrWidth];

    // same-cycle write wins over the stored value
    function automatic word_t readReg(regAddr_t addr, word_t stored, wbTrace_t w);
        word_t value;
        if (addr == '0) value = '0;
        else if (w.wen && w.wnum == addr) value = w.wdata;
        else value = stored;
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (wb.wen) begin
            regs[wb.wnum] <= wb.wdata;
        end
    end

    always_comb begin
        rsData = readReg(rsAddr, regs[rsAddr], wb);
        rtData = readReg(rtAddr, regs[rtAddr], wb);
    end

endmodule

// ==== mipsCore.f ====
logic/mipsPkg.sv
logic/instFetch.sv
logic/instDecode.sv
logic/regFile.sv
logic/execStage.sv
logic/pipeHazard.sv
logic/memAccess.sv
logic/mipsCore.sv
sim/mipsCore_asserts.sv
sim/mipsCoreTb.sv

// ==== sim/mipsCoreTb.sv ====
`timescale 1ns/10ps

module mipsCoreTb;
    import mipsPkg::*;

    localparam int imemWords = 64;
    localparam int dmemWords = 256;
    localparam int idleLimit = 200;

    logic     clk = 1'b0;
    logic     rstN;
    word_t    pc;
    logic     instEn;
    word_t    instr;
    logic     iCacheStall, dCacheStall;
    dataReq_t dataReq;
    word_t    memRdata;
    wbTrace_t wbTrace;

    word_t    imem [imemWords];
    word_t    dmem [dmemWords];
    word_t    refMem [dmemWords];
    word_t    refRegs [32];
    word_t    refPc, refNpc;
    wbTrace_t expWb [$];
    dataReq_t expSt [$];
    word_t    prog [$];
    logic     stallOn = 1'b0;
    int       progress = 0;
    word_t    fetchOff;

    always #2 clk = ~clk;

    mipsCore mipsCore_i (
        .clk(clk), .rstN(rstN),
        .pc(pc), .instEn(instEn), .instr(instr), .iCacheStall(iCacheStall),
        .dataReq(dataReq), .memRdata(memRdata), .dCacheStall(dCacheStall),
        .wbTrace(wbTrace)
    );

    // instruction memory starts at resetPc and reads nop past the program
    assign fetchOff = pc - resetPc;
    assign instr = !instEn ? 'x :
                   (fetchOff < 4 * imemWords) ? imem[fetchOff[7:2]] : '0;
    assign memRdata = dataReq.en ? dmem[dataReq.addr[9:2]] : 'x;  // no data without a request

    function automatic word_t fillWord(word_t addr);
        return (addr * 32'h01000193) ^ 32'hC3A50F1E;
    endfunction

    function automatic word_t rIns(int rs, int rt, int rd, int sa, funct_t fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic word_t iIns(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t jIns(opcode_t op, int idx);
        word_t addr;
        addr = resetPc + 4 * idx;
        return {op, addr[27:2]};
    endfunction

    // one instruction of the ISA including its branch delay slot
    function automatic void refStep();
        word_t ins, a, b, res, addr, target, sImm, zImm, memWord;
        opcode_t op;
        regAddr_t rs, rt, dest;
        logic wr, taken;
        logic [7:0] byteVal;
        dataReq_t st;
        wbTrace_t w;
        ins = prog[(refPc - resetPc) >> 2];
        op = opcode_t'(ins[31:26]);
        rs = ins[25:21];
        rt = ins[20:16];
        a = refRegs[rs];
        b = refRegs[rt];
        sImm = {{16{ins[15]}}, ins[15:0]};
        zImm = {16'h0000, ins[15:0]};
        addr = a + sImm;
        memWord = refMem[addr[9:2]];
        byteVal = memWord[8 * addr[1:0] +: 8];
        dest = rt;
        wr = op inside {opAddiu, opSlti, opAndi, opOri, opXori, opLui, opLw, opLb, opLbu};
        taken = 1'b0;
        res = '0;
        target = refPc + 4 + (sImm << 2);
        st = '0;
        case (op)
            opSpecial: begin
                dest = ins[15:11];
                wr = 1'b1;
                case (ins[5:0])
                    fnAddu:  res = a + b;
                    fnSubu:  res = a - b;
                    fnAnd:   res = a & b;
                    fnOr:    res = a | b;
                    fnXor:   res = a ^ b;
                    fnNor:   res = ~(a | b);
                    fnSlt:   res = {31'b0, $signed(a) < $signed(b)};
                    fnSltu:  res = {31'b0, a < b};
                    fnSll:   res = b << ins[10:6];
                    fnSrl:   res = b >> ins[10:6];
                    fnSra:   res = $signed(b) >>> ins[10:6];
                    default: wr = 1'b0;
                endcase
            end
            opJ, opJal: begin
                taken = 1'b1;
                target = {refNpc[31:28], ins[25:0], 2'b00};
                if (op == opJal) begin
                    dest = linkReg;
                    wr = 1'b1;
                    res = refPc + 8;
                end
            end
            opBeq:   taken = (a == b);
            opBne:   taken = (a != b);
            opAddiu: res = a + sImm;
            opSlti:  res = {31'b0, $signed(a) < $signed(sImm)};
            opAndi:  res = a & zImm;
            opOri:   res = a | zImm;
            opXori:  res = a ^ zImm;
            opLui:   res = {ins[15:0], 16'h0000};
            opLw:    res = memWord;
            opLb:    res = {{24{byteVal[7]}}, byteVal};
            opLbu:   res = {24'h0, byteVal};
            opSw, opSb: begin
                st.en = 1'b1;
                st.addr = {addr[31:2], 2'b00};
                st.wen = (op == opSw) ? 4'b1111 : 4'b0001 << addr[1:0];
                st.wdata = (op == opSw) ? b : {4{b[7:0]}};
                for (int l = 0; l < 4; l++) begin
                    if (st.wen[l]) refMem[addr[9:2]][8*l +: 8] = st.wdata[8*l +: 8];
                end
                expSt.push_back(st);
            end
            default: ;  // unknown opcodes do nothing
        endcase
        if (wr && dest != '0) begin
            refRegs[dest] = res;
            w.pc = refPc;
            w.wen = 1'b1;
            w.wnum = dest;
            w.wdata = res;
            expWb.push_back(w);
        end
        refPc = refNpc;
        refNpc = taken ? target : refNpc + 4;
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWb(wbTrace_t got, wbTrace_t exp);
        if (got.pc !== exp.pc)
            failRun($sformatf("FAIL wbTrace.pc got %h expected %h", got.pc, exp.pc));
        if (got.wnum !== exp.wnum)
            failRun($sformatf("FAIL wbTrace.wnum got %h expected %h", got.wnum, exp.wnum));
        if (got.wdata !== exp.wdata)
            failRun($sformatf("FAIL wbTrace.wdata got %h expected %h", got.wdata, exp.wdata));
    endtask

    task automatic checkStore(dataReq_t got, dataReq_t exp);
        word_t mask;
        mask = {{8{exp.wen[3]}}, {8{exp.wen[2]}}, {8{exp.wen[1]}}, {8{exp.wen[0]}}};
        if (got.addr !== exp.addr)
            failRun($sformatf("FAIL dataReq.addr got %h expected %h", got.addr, exp.addr));
        if (got.wen !== exp.wen)
            failRun($sformatf("FAIL dataReq.wen got %h expected %h", got.wen, exp.wen));
        if ((got.wdata & mask) !== (exp.wdata & mask))
            failRun($sformatf("FAIL dataReq.wdata got %h expected %h",
                              got.wdata & mask, exp.wdata & mask));
    endtask

    // a held trace or request counts once, on the edge that ends the stall
    always @(posedge clk) begin
        if (mipsCore_i.asserts_i.failCount != 0) failRun("a bound assertion failed");
        if (rstN === 1'b1 && dCacheStall === 1'b0) begin
            if (wbTrace.wen) begin
                if (expWb.size() == 0) failRun("an instruction retired that should not");
                else checkWb(wbTrace, expWb.pop_front());
                progress++;
            end
            if (dataReq.en && dataReq.wen != 4'b0000) begin
                if (expSt.size() == 0) failRun("a store was issued that should not");
                else checkStore(dataReq, expSt.pop_front());
                for (int l = 0; l < 4; l++) begin
                    if (dataReq.wen[l])
                        dmem[dataReq.addr[9:2]][8*l +: 8] <= dataReq.wdata[8*l +: 8];
                end
                progress++;
            end
        end
    end

    // random cache stalls only while stallOn is set
    initial begin
        void'($urandom(65342));
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
        forever begin
            @(posedge clk);
            iCacheStall <= stallOn && ($urandom % 4 == 0);
            dCacheStall <= stallOn && ($urandom % 5 == 0);
        end
    end

    task automatic runProgram(logic withStalls);
        int idle;
        int seen;
        int steps;
        stallOn = withStalls;
        @(posedge clk);
        rstN <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < imemWords; i++) imem[i] = (i < prog.size()) ? prog[i] : '0;
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = fillWord(i << 2);
            refMem[i] = dmem[i];
        end
        refPc = resetPc;
        refNpc = resetPc + 4;
        steps = 0;
        while (refPc - resetPc < 4 * prog.size() && steps < 1000) begin
            refStep();
            steps++;
        end
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        idle = 0;
        seen = progress;
        while (expWb.size() != 0 || expSt.size() != 0) begin
            @(negedge clk);
            if (progress != seen) begin
                seen = progress;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle >= idleLimit) failRun("timeout, no instruction retired in 200 cycles");
        end
        repeat (30) @(posedge clk);  // anything extra retiring now is an error
    endtask

    task automatic buildAlu();
        prog = {};
        prog.push_back(iIns(opAddiu, 0, 1, 16'h1234));
        prog.push_back(iIns(opAddiu, 1, 2, -5));
        prog.push_back(iIns(opLui, 0, 3, 16'h8765));
        prog.push_back(iIns(opOri, 3, 3, 16'h4321));
        prog.push_back(rIns(1, 2, 4, 0, fnAddu));
        prog.push_back(rIns(4, 3, 5, 0, fnSubu));
        prog.push_back(rIns(5, 3, 6, 0, fnAnd));
        prog.push_back(rIns(6, 1, 7, 0, fnOr));
        prog.push_back(rIns(7, 5, 8, 0, fnXor));
        prog.push_back(rIns(8, 0, 9, 0, fnNor));
        prog.push_back(rIns(3, 1, 10, 0, fnSlt));
        prog.push_back(rIns(3, 1, 11, 0, fnSltu));
        prog.push_back(rIns(0, 9, 12, 4, fnSll));
        prog.push_back(rIns(0, 3, 13, 8, fnSrl));
        prog.push_back(rIns(0, 3, 14, 8, fnSra));
        prog.push_back(iIns(opSlti, 3, 15, -1));
        prog.push_back(iIns(opAndi, 3, 16, 16'hFF0F));
        prog.push_back(iIns(opXori, 16, 17, 16'hFFFF));
        prog.push_back(rIns(17, 12, 18, 0, fnAddu));
    endtask

    task automatic buildMem();
        prog = {};
        prog.push_back(iIns(opAddiu, 0, 20, 16'h0040));
        prog.push_back(iIns(opLui, 0, 21, 16'h80F1));
        prog.push_back(iIns(opOri, 21, 21, 16'h7F22));
        prog.push_back(iIns(opSw, 20, 21, 0));
        prog.push_back(iIns(opSb, 20, 21, 5));
        prog.push_back(iIns(opSb, 20, 21, 7));
        prog.push_back(iIns(opLw, 20, 22, 0));
        prog.push_back(rIns(22, 22, 23, 0, fnAddu));  // load-use
        for (int off = 0; off < 4; off++) begin
            prog.push_back(iIns(opLb, 20, 24 + off, off));
            prog.push_back(iIns(opLbu, 20, 2 + off, off));
        end
        prog.push_back(iIns(opLw, 20, 6, 4));
        prog.push_back(iIns(opLb, 20, 7, 5));
        prog.push_back(rIns(7, 6, 8, 0, fnXor));
        prog.push_back(iIns(opLw, 20, 9, 16'h0040));
    endtask

    task automatic buildCtrl();
        prog = {};
        prog.push_back(iIns(opAddiu, 0, 1, 1));
        prog.push_back(iIns(opAddiu, 0, 2, 1));
        prog.push_back(iIns(opBeq, 1, 2, 3));      // taken to 6
        prog.push_back(iIns(opAddiu, 0, 3, 3));    // delay slot
        prog.push_back(iIns(opAddiu, 0, 4, 4));
        prog.push_back(iIns(opAddiu, 0, 5, 5));
        prog.push_back(iIns(opBne, 1, 2, 2));      // not taken
        prog.push_back(iIns(opAddiu, 0, 6, 6));
        prog.push_back(iIns(opAddiu, 0, 7, 7));
        prog.push_back(iIns(opBne, 1, 0, 2));      // taken to 12
        prog.push_back(iIns(opAddiu, 0, 8, 8));
        prog.push_back(iIns(opAddiu, 0, 9, 9));
        prog.push_back(iIns(opBeq, 1, 0, 1));      // not taken
        prog.push_back(iIns(opAddiu, 0, 10, 10));
        prog.push_back(jIns(opJal, 17));
        prog.push_back(iIns(opAddiu, 0, 11, 11));
        prog.push_back(iIns(opAddiu, 0, 12, 12));
        prog.push_back(jIns(opJ, 20));
        prog.push_back(rIns(31, 0, 13, 0, fnAddu));
        prog.push_back(iIns(opAddiu, 0, 14, 14));
        prog.push_back(iIns(opAddiu, 0, 15, 15));
    endtask

    task automatic buildOdd();
        prog = {};
        prog.push_back(iIns(opAddiu, 0, 0, 16'h0055));
        prog.push_back(rIns(1, 1, 0, 0, fnAddu));
        prog.push_back(32'hFC000000);              // opcode 0x3f
        prog.push_back(32'h7C221800);              // opcode 0x1f
        prog.push_back({6'h00, 5'd1, 5'd1, 5'd3, 5'd0, 6'h18});  // dropped funct
        prog.push_back(rIns(0, 1, 3, 0, fnAddu));
        prog.push_back(rIns(3, 0, 4, 0, fnOr));
    endtask

    initial begin
        rstN = 1'b0;
        for (int i = 0; i < 32; i++) refRegs[i] = '0;
        for (int pass = 0; pass < 2; pass++) begin
            buildAlu();
            runProgram(pass == 1);
            buildMem();
            runProgram(pass == 1);
            buildCtrl();
            runProgram(pass == 1);
            buildOdd();
            runProgram(pass == 1);
        end
        if (mipsCore_i.asserts_i.failCount == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            failRun("a bound assertion failed");
        end
    end

endmodule

// ==== sim/mipsCore_asserts.sv ====
`timescale 1ns/10ps

module mipsCore_asserts (
    input logic               clk,
    input logic               rstN,
    input mipsPkg::word_t     pc,
    input logic               instEn,
    input logic               dCacheStall,
    input mipsPkg::dataReq_t  dataReq,
    input mipsPkg::wbTrace_t  wbTrace
);
    import mipsPkg::*;

    int failCount = 0;

    // one edge into reset the outputs must be quiet
    quietInReset: assert property (@(posedge clk)
        !rstN |=> (!instEn && !dataReq.en && dataReq.wen == 4'b0000 && !wbTrace.wen))
        else begin
            failCount++;
            $error("control outputs active during reset");
        end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else begin
            failCount++;
            $error("pc not word aligned");
        end

    holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
        dCacheStall |=> $stable(dataReq))
        else begin
            failCount++;
            $error("dataReq changed under dCacheStall");
        end

    noWriteR0: assert property (@(posedge clk) disable iff (!rstN)
        wbTrace.wen |-> wbTrace.wnum != '0)
        else begin
            failCount++;
            $error("trace shows a write to register 0");
        end

endmodule

bind mipsCore mipsCore_asserts asserts_i (
    .clk(clk), .rstN(rstN), .pc(pc), .instEn(instEn),
    .dCacheStall(dCacheStall), .dataReq(dataReq), .wbTrace(wbTrace)
);
